/* common/chip_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map, widths, status codes and shared types of the
// subsystem. Modules import it inside their bodies.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package chip_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Main RAM
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int RAM_BYTES = RAM_WORDS * 4;

  // GPIO block, 256 bytes of register space
  localparam int NUM_GPIOS = 16;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 16'h1000;

  localparam logic [7:0] GPIO_DATA_OUT   = 8'h00;
  localparam logic [7:0] GPIO_OE         = 8'h04;
  localparam logic [7:0] GPIO_MASKED_OUT = 8'h08;
  localparam logic [7:0] GPIO_DATA_IN    = 8'h0C;

  // Software test status word inside the RAM
  localparam logic [ADDR_W-1:0] SW_STATUS_ADDR = 16'h0FF0;
  localparam logic [DATA_W-1:0] SW_PASS_CODE   = 32'h0000_900D;
  localparam logic [DATA_W-1:0] SW_FAIL_CODE   = 32'h0000_BAAD;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [RAM_AW-1:0]    word_addr_t;
  typedef logic [NUM_GPIOS-1:0] gpio_t;

  // Result monitor states
  typedef enum logic [1:0] {
    ST_RUNNING = 2'd0,
    ST_PASSED  = 2'd1,
    ST_FAILED  = 2'd2
  } sw_state_e;

endpackage

`default_nettype wire

/* common/apb_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB signal bundle. The host modport issues transfers, the
// target modport answers them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface apb_if;
  import chip_pkg::*;

  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  data_t pwdata;
  data_t prdata;
  logic  pready;
  logic  pslverr;

  modport host (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport target (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

/* common/mem_wr_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM write commit bundle, driven by the RAM and snooped by
// the test status monitor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface mem_wr_if;
  import chip_pkg::*;

  logic       commit;
  word_addr_t word_addr;
  data_t      wdata;

  modport ram (output commit, word_addr, wdata);

  modport monitor (input commit, word_addr, wdata);

endinterface

`default_nettype wire

/* hw/chip_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single host APB crossbar. Routes each transfer to the RAM or
// the GPIO block and answers unmapped addresses with an error.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module chip_xbar (
  apb_if.target host_o,
  apb_if.host   ram_o,
  apb_if.host   gpio_o
);
  import chip_pkg::*;

  typedef enum logic [1:0] {
    SEL_RAM  = 2'd0,
    SEL_GPIO = 2'd1,
    SEL_MISS = 2'd2
  } sel_e;

  sel_e sel;

  // Request side, only psel is steered
  assign ram_o.penable  = host_o.penable;
  assign ram_o.pwrite   = host_o.pwrite;
  assign ram_o.paddr    = host_o.paddr;
  assign ram_o.pwdata   = host_o.pwdata;

  assign gpio_o.penable = host_o.penable;
  assign gpio_o.pwrite  = host_o.pwrite;
  assign gpio_o.paddr   = host_o.paddr;
  assign gpio_o.pwdata  = host_o.pwdata;

  always_comb begin
    if (host_o.paddr < addr_t'(RAM_BYTES)) begin
      sel = SEL_RAM;
    end else if (host_o.paddr[ADDR_W-1:8] == GPIO_BASE[ADDR_W-1:8]) begin
      sel = SEL_GPIO;
    end else begin
      sel = SEL_MISS;
    end

    ram_o.psel  = host_o.psel && (sel == SEL_RAM);
    gpio_o.psel = host_o.psel && (sel == SEL_GPIO);

    // Response mux, a miss is answered here in the first access cycle
    case (sel)
      SEL_RAM: begin
        host_o.prdata  = ram_o.prdata;
        host_o.pready  = ram_o.pready;
        host_o.pslverr = ram_o.pslverr;
      end
      SEL_GPIO: begin
        host_o.prdata  = gpio_o.prdata;
        host_o.pready  = gpio_o.pready;
        host_o.pslverr = gpio_o.pslverr;
      end
      default: begin
        host_o.prdata  = '0;
        host_o.pready  = host_o.psel && host_o.penable;
        host_o.pslverr = host_o.psel && host_o.penable;
      end
    endcase

    // One target at most sees a select
    assert (!(ram_o.psel && gpio_o.psel))
      else $error("psel raised toward RAM and GPIO together");
  end

endmodule

`default_nettype wire

/* ram_main/ram_main.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main RAM behind APB with one wait state. Completed writes are
// reported on the commit port for the status monitor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ram_main (
  input  logic     clk_i,
  input  logic     rst_i,
  apb_if.target    bus_i,
  mem_wr_if.ram    wr_o
);
  import chip_pkg::*;

  data_t      mem_q [RAM_WORDS];
  data_t      rdata_q;
  logic       ack_q;
  logic       first_acc;
  word_addr_t waddr;

  // Word index from the byte address
  assign waddr     = bus_i.paddr[RAM_AW+1:2];
  assign first_acc = bus_i.psel && bus_i.penable && !ack_q;

  // Wait state tracking, high in the second access cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= first_acc;
    end
  end

  // Storage and registered read
  always_ff @(posedge clk_i) begin
    if (first_acc) begin
      if (bus_i.pwrite) begin
        mem_q[waddr] <= bus_i.pwdata;
      end else begin
        rdata_q <= mem_q[waddr];
      end
    end
  end

  assign bus_i.pready  = ack_q;
  assign bus_i.pslverr = 1'b0;
  assign bus_i.prdata  = rdata_q;

  // Commit pulses in the completing cycle of a write
  assign wr_o.commit    = ack_q && bus_i.psel && bus_i.penable && bus_i.pwrite;
  assign wr_o.word_addr = waddr;
  assign wr_o.wdata     = bus_i.pwdata;

  // Host holds the address across the wait state
  a_paddr_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (bus_i.psel && !bus_i.pready) |=> $stable(bus_i.paddr)
  ) else $error("paddr changed during a pending RAM transfer");

endmodule

`default_nettype wire

/* gpio/gpio.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO register block on APB, zero wait states. Output, enable,
// masked output write and a synchronized input register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gpio (
  input  logic            clk_i,
  input  logic            rst_i,
  apb_if.target           bus_i,
  input  chip_pkg::gpio_t gpio_in_i,
  output chip_pkg::gpio_t gpio_out_o,
  output chip_pkg::gpio_t gpio_oe_o
);
  import chip_pkg::*;

  gpio_t      data_out_q;
  gpio_t      oe_q;
  gpio_t      in_meta_q;
  gpio_t      in_sync_q;
  gpio_t      mask;
  logic [7:0] offset;
  logic       access;
  logic       bad_req;
  logic       wr_en;

  assign offset = bus_i.paddr[7:0];
  assign access = bus_i.psel && bus_i.penable;
  assign mask   = bus_i.pwdata[2*NUM_GPIOS-1:NUM_GPIOS];

  // Illegal offsets and wrong directions
  always_comb begin
    case (offset)
      GPIO_DATA_OUT:   bad_req = 1'b0;
      GPIO_OE:         bad_req = 1'b0;
      GPIO_MASKED_OUT: bad_req = !bus_i.pwrite;
      GPIO_DATA_IN:    bad_req = bus_i.pwrite;
      default:         bad_req = 1'b1;
    endcase
  end

  assign wr_en = access && bus_i.pwrite && !bad_req;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_out_q <= '0;
      oe_q       <= '0;
    end else if (wr_en) begin
      case (offset)
        GPIO_DATA_OUT: data_out_q <= bus_i.pwdata[NUM_GPIOS-1:0];
        GPIO_OE:       oe_q       <= bus_i.pwdata[NUM_GPIOS-1:0];
        // Only masked bits take the new data
        GPIO_MASKED_OUT: begin
          data_out_q <= (data_out_q & ~mask) | (bus_i.pwdata[NUM_GPIOS-1:0] & mask);
        end
        default: ;
      endcase
    end
  end

  // Two flop input synchronizer
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // Read mux
  always_comb begin
    case (offset)
      GPIO_DATA_OUT: bus_i.prdata = data_t'(data_out_q);
      GPIO_OE:       bus_i.prdata = data_t'(oe_q);
      GPIO_DATA_IN:  bus_i.prdata = data_t'(in_sync_q);
      default:       bus_i.prdata = '0;
    endcase
  end

  assign bus_i.pready  = access;
  assign bus_i.pslverr = access && bad_req;

  assign gpio_out_o = data_out_q;
  assign gpio_oe_o  = oe_q;

endmodule

`default_nettype wire

/* hw/sw_status.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Software test status monitor. Watches RAM commits to the
// status word and holds a sticky done and passed result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sw_status (
  input  logic       clk_i,
  input  logic       rst_i,
  mem_wr_if.monitor  wr_i,
  output logic       test_done_o,
  output logic       test_passed_o
);
  import chip_pkg::*;

  sw_state_e state_q;
  logic      status_hit;

  assign status_hit = wr_i.commit && (wr_i.word_addr == SW_STATUS_ADDR[RAM_AW+1:2]);

  // First pass or fail code wins, later writes are ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_RUNNING;
    end else if (state_q == ST_RUNNING && status_hit) begin
      if (wr_i.wdata == SW_PASS_CODE) begin
        state_q <= ST_PASSED;
      end else if (wr_i.wdata == SW_FAIL_CODE) begin
        state_q <= ST_FAILED;
      end
    end
  end

  assign test_done_o   = (state_q != ST_RUNNING);
  assign test_passed_o = (state_q == ST_PASSED);

  a_passed_done : assert property (
    @(posedge clk_i) disable iff (rst_i)
    test_passed_o |-> test_done_o
  ) else $error("test passed without test done");

endmodule

`default_nettype wire

/* hw/chip_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subsystem top. Plain APB host ports feed the crossbar, which
// reaches the main RAM and the GPIO block.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module chip_top (
  input  logic            clk_i,
  input  logic            rst_i,
  // APB host
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  chip_pkg::addr_t paddr_i,
  input  chip_pkg::data_t pwdata_i,
  output chip_pkg::data_t prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  // Pins
  input  chip_pkg::gpio_t gpio_in_i,
  output chip_pkg::gpio_t gpio_out_o,
  output chip_pkg::gpio_t gpio_oe_o,
  // Test result
  output logic            test_done_o,
  output logic            test_passed_o
);

  apb_if    host_bus ();
  apb_if    ram_bus ();
  apb_if    gpio_bus ();
  mem_wr_if ram_wr ();

  assign host_bus.psel    = psel_i;
  assign host_bus.penable = penable_i;
  assign host_bus.pwrite  = pwrite_i;
  assign host_bus.paddr   = paddr_i;
  assign host_bus.pwdata  = pwdata_i;
  assign prdata_o         = host_bus.prdata;
  assign pready_o         = host_bus.pready;
  assign pslverr_o        = host_bus.pslverr;

  chip_xbar u_xbar (
    .host_o (host_bus.target),
    .ram_o  (ram_bus.host),
    .gpio_o (gpio_bus.host)
  );

  ram_main u_ram_main (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (ram_bus.target),
    .wr_o  (ram_wr.ram)
  );

  gpio u_gpio (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus_i      (gpio_bus.target),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  // Result monitor snoops RAM commits
  sw_status u_sw_status (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wr_i          (ram_wr.monitor),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o)
  );

endmodule

`default_nettype wire

/* verification/tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the chip subsystem. Acts as the APB host, checks
// each transfer and the pins against a reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb;
  import chip_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 5;
  localparam int RAM_N          = 32;
  localparam int GPIO_N         = 8;
  localparam int IN_N           = 4;
  // RAM, GPIO registers, GPIO input, errors, status word, reset
  localparam int XFER_COUNT     = 2 * RAM_N + 6 * GPIO_N + IN_N + 13 + 6 + 1;
  localparam int TIMEOUT_CYCLES = XFER_COUNT * 10 + 2 * RESET_CYCLES;

  typedef struct packed {
    data_t prdata;
    logic  pslverr;
    int    cycles;
  } resp_t;

  logic  clk_i;
  logic  rst_i;
  logic  psel_i;
  logic  penable_i;
  logic  pwrite_i;
  addr_t paddr_i;
  data_t pwdata_i;
  data_t prdata_o;
  logic  pready_o;
  logic  pslverr_o;
  gpio_t gpio_in_i;
  gpio_t gpio_out_o;
  gpio_t gpio_oe_o;
  logic  test_done_o;
  logic  test_passed_o;

  // Reference model state
  data_t ram_mirror [RAM_WORDS];
  logic  ram_written [RAM_WORDS];
  gpio_t out_model;
  gpio_t oe_model;
  logic  done_model;
  logic  passed_model;
  int    acc_cycles;
  int    xfers_done;
  resp_t want;

  logic [31:0] lfsr_q;
  addr_t       wr_addrs [RAM_N];
  int          order [RAM_N];

  chip_top dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .gpio_in_i     (gpio_in_i),
    .gpio_out_o    (gpio_out_o),
    .gpio_oe_o     (gpio_oe_o),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input data_t exp_v, input data_t got_v);
    fail_run($sformatf("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
                       $time, name, exp_v, got_v));
  endtask

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output data_t val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic addr_t gpio_addr(input logic [7:0] offset);
    return {GPIO_BASE[15:8], offset};
  endfunction

  // Expected response of one transfer from the address map rules
  function automatic resp_t expect_resp(input addr_t addr, input logic write);
    resp_t r;
    r.prdata  = '0;
    r.pslverr = 1'b0;
    r.cycles  = 1;
    if (addr < GPIO_BASE) begin
      // One wait state on the RAM
      r.cycles = 2;
      r.prdata = ram_mirror[addr[11:2]];
    end else if (addr[15:8] == GPIO_BASE[15:8]) begin
      case (addr[7:0])
        GPIO_DATA_OUT:   r.prdata = {16'h0, out_model};
        GPIO_OE:         r.prdata = {16'h0, oe_model};
        GPIO_MASKED_OUT: r.pslverr = !write;
        GPIO_DATA_IN: begin
          r.pslverr = write;
          r.prdata  = {16'h0, gpio_in_i};
        end
        default:         r.pslverr = 1'b1;
      endcase
    end else begin
      r.pslverr = 1'b1;
    end
    return r;
  endfunction

  task automatic apply_write(input addr_t addr, input data_t wdata);
    int b;
    if (addr < GPIO_BASE) begin
      ram_mirror[addr[11:2]]  = wdata;
      ram_written[addr[11:2]] = 1'b1;
      // First status code settles the result
      if (addr[11:2] == SW_STATUS_ADDR[11:2] && !done_model) begin
        if (wdata == SW_PASS_CODE) begin
          done_model   = 1'b1;
          passed_model = 1'b1;
        end else if (wdata == SW_FAIL_CODE) begin
          done_model = 1'b1;
        end
      end
    end else begin
      case (addr[7:0])
        GPIO_DATA_OUT:   out_model = wdata[15:0];
        GPIO_OE:         oe_model  = wdata[15:0];
        // Upper half picks the pins, lower half gives their values
        GPIO_MASKED_OUT: begin
          for (b = 0; b < NUM_GPIOS; b++) begin
            if (wdata[16 + b]) begin
              out_model[b] = wdata[b];
            end
          end
        end
        default: ;
      endcase
    end
  endtask

  // Compare process, samples on the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      out_model    = '0;
      oe_model     = '0;
      done_model   = 1'b0;
      passed_model = 1'b0;
      ram_written  = '{default: 1'b0};
      acc_cycles   = 0;
    end else begin
      assert (gpio_out_o === out_model)
        else report_mismatch("gpio_out_o", data_t'(out_model), data_t'(gpio_out_o));
      assert (gpio_oe_o === oe_model)
        else report_mismatch("gpio_oe_o", data_t'(oe_model), data_t'(gpio_oe_o));
      assert (test_done_o === done_model)
        else report_mismatch("test_done_o", data_t'(done_model), data_t'(test_done_o));
      assert (test_passed_o === passed_model)
        else report_mismatch("test_passed_o", data_t'(passed_model), data_t'(test_passed_o));
      if (psel_i && penable_i) begin
        acc_cycles = acc_cycles + 1;
      end else begin
        assert (pready_o === 1'b0) else fail_run("pready_o is high outside an access cycle");
      end
      if (psel_i && penable_i && pready_o) begin
        want = expect_resp(paddr_i, pwrite_i);
        if (!pwrite_i && paddr_i < GPIO_BASE) begin
          assert (ram_written[paddr_i[11:2]] === 1'b1)
            else fail_run("the testbench read a RAM word that was never written");
        end
        assert (acc_cycles == want.cycles)
          else fail_run($sformatf("transfer to 0x%04h took %0d access cycles instead of %0d",
                                  paddr_i, acc_cycles, want.cycles));
        assert (pslverr_o === want.pslverr)
          else report_mismatch("pslverr_o", data_t'(want.pslverr), data_t'(pslverr_o));
        if (!pwrite_i && !want.pslverr) begin
          assert (prdata_o === want.prdata)
            else report_mismatch("prdata_o", want.prdata, prdata_o);
        end
        if (pwrite_i && !want.pslverr) begin
          apply_write(paddr_i, pwdata_i);
        end
        acc_cycles = 0;
        xfers_done = xfers_done + 1;
      end
    end
  end

  task automatic apply_reset;
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  // One APB transfer, holds the request until pready
  task automatic apb_xfer(input addr_t addr, input logic write, input data_t wdata);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    while (!pready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    fail_run($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin : main_seq
    data_t v;
    data_t wv;
    int    i;
    int    j;
    int    tmp;
    clk_i     = 1'b0;
    lfsr_q    = 32'head3_314a;
    rst_i     <= 1'b1;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= '0;
    pwdata_i  <= '0;
    gpio_in_i <= '0;
    apply_reset();

    // Random RAM writes, status word excluded
    for (i = 0; i < RAM_N; i++) begin
      draw_bits(10, v);
      if (v[9:0] == SW_STATUS_ADDR[11:2]) begin
        v[0] = ~v[0];
      end
      wr_addrs[i] = {4'h0, v[9:0], 2'b00};
      draw_bits(32, v);
      apb_xfer(wr_addrs[i], 1'b1, v);
      order[i] = i;
    end
    for (i = RAM_N - 1; i > 0; i--) begin
      draw_bits(5, v);
      j        = int'(v[4:0]) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < RAM_N; i++) begin
      apb_xfer(wr_addrs[order[i]], 1'b0, '0);
    end

    // GPIO output, enable and masked writes
    for (i = 0; i < GPIO_N; i++) begin
      draw_bits(32, v);
      apb_xfer(gpio_addr(GPIO_DATA_OUT), 1'b1, v);
      draw_bits(32, v);
      apb_xfer(gpio_addr(GPIO_OE), 1'b1, v);
      apb_xfer(gpio_addr(GPIO_DATA_OUT), 1'b0, '0);
      apb_xfer(gpio_addr(GPIO_OE), 1'b0, '0);
      draw_bits(32, v);
      apb_xfer(gpio_addr(GPIO_MASKED_OUT), 1'b1, v);
      apb_xfer(gpio_addr(GPIO_DATA_OUT), 1'b0, '0);
    end

    // Input held long enough to pass the synchronizer
    for (i = 0; i < IN_N; i++) begin
      draw_bits(16, v);
      @(posedge clk_i);
      gpio_in_i <= v[15:0];
      repeat (3) @(posedge clk_i);
      apb_xfer(gpio_addr(GPIO_DATA_IN), 1'b0, '0);
    end

    // Error responses, some aliased onto written RAM words
    draw_bits(32, wv);
    apb_xfer({4'h8, wr_addrs[0][11:0]}, 1'b1, wv);
    apb_xfer({4'hF, wr_addrs[1][11:0]}, 1'b1, wv);
    apb_xfer(16'h1100, 1'b0, '0);
    apb_xfer(gpio_addr(8'h10), 1'b1, wv);
    apb_xfer(gpio_addr(8'hFC), 1'b0, '0);
    apb_xfer(gpio_addr(8'h02), 1'b1, wv);
    apb_xfer(gpio_addr(GPIO_DATA_IN), 1'b1, wv);
    apb_xfer(gpio_addr(GPIO_MASKED_OUT), 1'b0, '0);
    apb_xfer(16'h1104, 1'b1, wv);
    apb_xfer(gpio_addr(GPIO_DATA_OUT), 1'b0, '0);
    apb_xfer(gpio_addr(GPIO_OE), 1'b0, '0);
    apb_xfer(wr_addrs[0], 1'b0, '0);
    apb_xfer(wr_addrs[1], 1'b0, '0);

    // Status word, plain values first
    apb_xfer(SW_STATUS_ADDR, 1'b1, 32'h0000_0000);
    apb_xfer(SW_STATUS_ADDR, 1'b1, 32'h0000_900C);
    apb_xfer(SW_STATUS_ADDR, 1'b1, 32'hBAAD_0000);
    apb_xfer(SW_STATUS_ADDR, 1'b0, '0);
    @(negedge clk_i);
    assert (test_done_o === 1'b0) else fail_run("test_done_o rose without a status code");
    apb_xfer(SW_STATUS_ADDR, 1'b1, SW_PASS_CODE);
    @(negedge clk_i);
    assert (test_done_o === 1'b1 && test_passed_o === 1'b1)
      else fail_run("the pass code did not raise test_done_o and test_passed_o");
    apb_xfer(SW_STATUS_ADDR, 1'b1, SW_FAIL_CODE);
    @(negedge clk_i);
    assert (test_done_o === 1'b1 && test_passed_o === 1'b1)
      else fail_run("a fail code after the pass code changed the result");

    // Fresh reset, then a fail code
    apply_reset();
    @(negedge clk_i);
    assert (test_done_o === 1'b0 && test_passed_o === 1'b0)
      else fail_run("the test result survived the reset");
    apb_xfer(SW_STATUS_ADDR, 1'b1, SW_FAIL_CODE);
    @(negedge clk_i);
    assert (test_done_o === 1'b1 && test_passed_o === 1'b0)
      else fail_run("the fail code did not raise test_done_o alone");

    repeat (2) @(negedge clk_i);
    if (xfers_done == XFER_COUNT) begin
      $display("Test passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d of %0d transfers were checked", xfers_done, XFER_COUNT));
    end
  end

endmodule

`default_nettype wire

/* project.f */
common/chip_pkg.sv
common/apb_if.sv
common/mem_wr_if.sv
hw/chip_xbar.sv
ram_main/ram_main.sv
gpio/gpio.sv
hw/sw_status.sv
hw/chip_top.sv
verification/tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb -f project.f \
  && ./obj_dir/Vtb | tee /dev/stderr | grep -x "Test passed" > /dev/null \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
